// ==== Makefile ====
# Verilator build and run of the CLINT testbench.
TOP := clint_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== clint_access_decode.sv ====
`timescale 1ns/1ps

module clint_access_decode
  import clint_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  logic           rd_en,
  input  logic           wr_en,
  input  logic [2:0]     addr,
  output logic           msip_we,
  output logic           mtime_we,
  output logic           mtimecmp_we,
  output logic           upper_half,
  output clint_reg_sel_e read_sel,
  output logic           busy
);

  logic busy_q;

  // bits 1:0 pick the register, bit 2 picks the half in 32-bit mode.
  assign read_sel   = clint_reg_sel_e'(addr[1:0]);
  assign upper_half = addr[2];

  assign msip_we     = wr_en && (read_sel == sel_msip);
  assign mtime_we    = wr_en && (read_sel == sel_mtime);
  assign mtimecmp_we = wr_en && (read_sel == sel_mtimecmp);

  // busy follows an access by one cycle.
  // a held strobe makes it toggle, since it clears itself.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= rd_en || wr_en;
    end
  end

  assign busy = busy_q;

  // the bus never issues a read and a write in the same cycle.
  a_strobes_exclusive : assert property (
    @(posedge clock) disable iff (reset)
    !(rd_en && wr_en)
  ) else $error("rd_en and wr_en high together");

endmodule

// ==== clint_pkg.sv ====
package clint_pkg;

  // register selected by addr bits 1:0.
  typedef enum logic [1:0] {
    sel_msip     = 2'b00,
    sel_unmapped = 2'b01,
    sel_mtime    = 2'b10,
    sel_mtimecmp = 2'b11
  } clint_reg_sel_e;

  // data width of the access port, 32 or 64.
  parameter int default_xlen = 32;

  // clocks per mtime increment.
  parameter int default_tick_cycles = 100;

  // mtime and mtimecmp are 64 bits wide for either xlen.
  parameter int timer_width = 64;

  // width of one half-word access in 32-bit mode.
  parameter int half_width = 32;

endpackage

// ==== clint_readback_irq.sv ====
`timescale 1ns/1ps

module clint_readback_irq
  import clint_pkg::*;
#(
  parameter int xlen = default_xlen
) (
  input  logic                   clock,
  input  logic                   reset,
  input  clint_reg_sel_e         read_sel,
  input  logic                   upper_half,
  input  logic [xlen-1:0]        msip_q,
  input  logic [timer_width-1:0] mtime_q,
  input  logic [timer_width-1:0] mtimecmp_q,
  output logic [xlen-1:0]        rd_data,
  output logic                   timer_irq,
  output logic                   software_irq
);

  logic [xlen-1:0] mtime_view;
  logic [xlen-1:0] mtimecmp_view;
  logic            timer_hit;

  generate
    if (xlen == half_width) begin : g_half_reads
      assign mtime_view = upper_half ? mtime_q[timer_width-1:half_width] :
                                       mtime_q[half_width-1:0];
      assign mtimecmp_view = upper_half ? mtimecmp_q[timer_width-1:half_width] :
                                          mtimecmp_q[half_width-1:0];
    end else begin : g_full_reads
      assign mtime_view    = mtime_q;
      assign mtimecmp_view = mtimecmp_q;
    end
  endgenerate

  always_comb begin
    case (read_sel)
      sel_msip:     rd_data = msip_q;
      sel_mtime:    rd_data = mtime_view;
      sel_mtimecmp: rd_data = mtimecmp_view;
      default:      rd_data = '0;
    endcase
  end

  // unsigned compare, registered once.
  assign timer_hit = (mtime_q >= mtimecmp_q);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      timer_irq <= 1'b0;
    end else begin
      timer_irq <= timer_hit;
    end
  end

  assign software_irq = msip_q[0];

  a_timer_irq_cause : assert property (
    @(posedge clock) disable iff (reset)
    timer_irq |-> $past(mtime_q >= mtimecmp_q)
  ) else $error("timer_irq without a compare hit");

endmodule

// ==== clint_tb.sv ====
`timescale 1ns/1ps

module clint_tb
  import clint_pkg::*;
();

  localparam int xlen          = 32;
  localparam int tick_cycles   = 4;
  localparam int sample_delay  = 2;
  localparam int reset_timeout = 50;
  localparam int irq_timeout   = 64;
  localparam int drop_timeout  = 2;
  localparam int advance_ticks = 5;
  localparam logic [31:0] lfsr_seed = 32'h0d3789f8;
  localparam logic [31:0] lfsr_taps = 32'h80200003;

  logic                   clock;
  logic                   reset;
  logic                   rd_en;
  logic                   wr_en;
  logic [2:0]             addr;
  logic [xlen-1:0]        wr_data;
  logic [xlen-1:0]        rd_data;
  logic                   busy;
  logic [xlen-1:0]        msip;
  logic [timer_width-1:0] mtime;
  logic [timer_width-1:0] mtimecmp;
  logic                   timer_irq;
  logic                   software_irq;

  logic [31:0] lfsr_state;
  int          fail_count;

  tb_clock_gen #(
    .half_period  (4),
    .reset_cycles (5)
  ) u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  clint_top #(
    .xlen        (xlen),
    .tick_cycles (tick_cycles)
  ) uut (
    .clock        (clock),
    .reset        (reset),
    .rd_en        (rd_en),
    .wr_en        (wr_en),
    .addr         (addr),
    .wr_data      (wr_data),
    .rd_data      (rd_data),
    .busy         (busy),
    .msip         (msip),
    .mtime        (mtime),
    .mtimecmp     (mtimecmp),
    .timer_irq    (timer_irq),
    .software_irq (software_irq)
  );

  task automatic stop_on_failure();
    fail_count++;
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic abort_with(input string reason);
    $display("%s", reason);
    stop_on_failure();
  endtask

  // passes when got lies in expected .. expected + slack.
  task automatic check_data(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] expected, input int unsigned slack);
    logic [xlen-1:0] excess;
    excess = got - expected;
    if ($isunknown(got) || got < expected || excess > xlen'(slack)) begin
      if (slack == 0) begin
        $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
      end else begin
        $display("FAILED %s: got 0x%h, expected 0x%h to 0x%h", name, got, expected,
                 expected + xlen'(slack));
      end
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
      stop_on_failure();
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ lfsr_taps;
    end else begin
      return state >> 1;
    end
  endfunction

  // one LFSR step per bit taken.
  task automatic next_random(output logic [xlen-1:0] value);
    int i;
    value = '0;
    for (i = 0; i < xlen; i++) begin
      value = {value[xlen-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [2:0] reg_addr(input clint_reg_sel_e sel, input logic upper);
    return {upper, sel};
  endfunction

  // bus tasks start and end on a falling edge.
  task automatic write_reg(input logic [2:0] a, input logic [xlen-1:0] data);
    addr    = a;
    wr_data = data;
    wr_en   = 1'b1;
    @(negedge clock);
    wr_en = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] a, output logic [xlen-1:0] data);
    addr  = a;
    rd_en = 1'b1;
    #(sample_delay);
    data = rd_data;
    @(negedge clock);
    rd_en = 1'b0;
  endtask

  // reset drops on a falling edge, so it is sampled on the rising edge.
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (reset !== 1'b0 && cycles < reset_timeout) begin
      @(posedge clock);
      cycles++;
    end
    if (reset !== 1'b0) begin
      abort_with("timeout waiting for reset to be released");
    end
    @(negedge clock);
  endtask

  task automatic test_reset_state();
    logic [xlen-1:0] value;
    check_flag("busy", busy, 1'b0);
    check_flag("timer_irq", timer_irq, 1'b0);
    check_flag("software_irq", software_irq, 1'b0);
    read_reg(reg_addr(sel_msip, 1'b0), value);
    check_data("msip", value, '0, 0);
    read_reg(reg_addr(sel_mtimecmp, 1'b0), value);
    check_data("mtimecmp_lo", value, '1, 0);
    read_reg(reg_addr(sel_mtimecmp, 1'b1), value);
    check_data("mtimecmp_hi", value, '1, 0);
    read_reg(reg_addr(sel_mtime, 1'b0), value);
    check_data("mtime_lo", value, '0, 2);
    read_reg(reg_addr(sel_mtime, 1'b1), value);
    check_data("mtime_hi", value, '0, 0);
  endtask

  task automatic test_msip();
    logic [xlen-1:0] value;
    logic [xlen-1:0] junk;
    logic [xlen-1:0] readback;
    int              i;
    for (i = 0; i < 4; i++) begin
      next_random(value);
      // bit 0 alternates so software_irq is seen at both levels.
      value[0] = i[0];
      write_reg(reg_addr(sel_msip, 1'b0), value);
      check_flag("software_irq", software_irq, value[0]);
      check_data("msip port", msip, value, 0);
      read_reg(reg_addr(sel_msip, 1'b0), readback);
      check_data("msip", readback, value, 0);
    end
    next_random(junk);
    write_reg(reg_addr(sel_unmapped, 1'b0), junk);
    read_reg(reg_addr(sel_unmapped, 1'b0), readback);
    check_data("unmapped", readback, '0, 0);
    read_reg(reg_addr(sel_msip, 1'b0), readback);
    check_data("msip", readback, value, 0);
    write_reg(reg_addr(sel_msip, 1'b0), '0);
    check_flag("software_irq", software_irq, 1'b0);
  endtask

  task automatic test_mtimecmp_halves();
    logic [xlen-1:0] low;
    logic [xlen-1:0] high;
    logic [xlen-1:0] low2;
    logic [xlen-1:0] readback;
    next_random(low);
    next_random(high);
    next_random(low2);
    write_reg(reg_addr(sel_mtimecmp, 1'b0), low);
    read_reg(reg_addr(sel_mtimecmp, 1'b0), readback);
    check_data("mtimecmp_lo", readback, low, 0);
    read_reg(reg_addr(sel_mtimecmp, 1'b1), readback);
    check_data("mtimecmp_hi", readback, '1, 0);
    write_reg(reg_addr(sel_mtimecmp, 1'b1), high);
    read_reg(reg_addr(sel_mtimecmp, 1'b1), readback);
    check_data("mtimecmp_hi", readback, high, 0);
    read_reg(reg_addr(sel_mtimecmp, 1'b0), readback);
    check_data("mtimecmp_lo", readback, low, 0);
    write_reg(reg_addr(sel_mtimecmp, 1'b0), low2);
    read_reg(reg_addr(sel_mtimecmp, 1'b0), readback);
    check_data("mtimecmp_lo", readback, low2, 0);
    read_reg(reg_addr(sel_mtimecmp, 1'b1), readback);
    check_data("mtimecmp_hi", readback, high, 0);
    check_data("mtimecmp port lo", mtimecmp[half_width-1:0], low2, 0);
    check_data("mtimecmp port hi", mtimecmp[timer_width-1:half_width], high, 0);
  endtask

  task automatic test_mtime();
    logic [xlen-1:0] w_lo;
    logic [xlen-1:0] w_hi;
    logic [xlen-1:0] first_lo;
    logic [xlen-1:0] later_lo;
    logic [xlen-1:0] readback;
    next_random(w_lo);
    next_random(w_hi);
    // keeps the low half far from a carry into the high half.
    w_lo[xlen-1] = 1'b0;
    write_reg(reg_addr(sel_mtime, 1'b0), w_lo);
    write_reg(reg_addr(sel_mtime, 1'b1), w_hi);
    read_reg(reg_addr(sel_mtime, 1'b0), first_lo);
    check_data("mtime_lo", first_lo, w_lo, 1);
    check_data("mtime port lo", mtime[half_width-1:0], w_lo, 1);
    read_reg(reg_addr(sel_mtime, 1'b1), readback);
    check_data("mtime_hi", readback, w_hi, 0);
    check_data("mtime port hi", mtime[timer_width-1:half_width], w_hi, 0);
    // the two low-half samples lie exactly tick_cycles*advance_ticks clocks apart.
    repeat (tick_cycles * advance_ticks - 2) @(negedge clock);
    read_reg(reg_addr(sel_mtime, 1'b0), later_lo);
    check_data("mtime_lo", later_lo, first_lo + xlen'(advance_ticks), 1);
  endtask

  task automatic test_timer_irq();
    logic [xlen-1:0] start_lo;
    logic [xlen-1:0] start_hi;
    logic [xlen-1:0] target_lo;
    logic [xlen-1:0] now_lo;
    logic [xlen-1:0] now_hi;
    int              cycles;
    read_reg(reg_addr(sel_mtime, 1'b0), start_lo);
    read_reg(reg_addr(sel_mtime, 1'b1), start_hi);
    target_lo = start_lo + xlen'(3);
    write_reg(reg_addr(sel_mtimecmp, 1'b0), '1);
    write_reg(reg_addr(sel_mtimecmp, 1'b1), start_hi);
    write_reg(reg_addr(sel_mtimecmp, 1'b0), target_lo);
    check_flag("timer_irq", timer_irq, 1'b0);
    cycles = 0;
    while (timer_irq !== 1'b1 && cycles < irq_timeout) begin
      @(negedge clock);
      cycles++;
    end
    if (timer_irq !== 1'b1) begin
      abort_with("timeout waiting for timer_irq after mtimecmp was set");
    end
    read_reg(reg_addr(sel_mtime, 1'b0), now_lo);
    read_reg(reg_addr(sel_mtime, 1'b1), now_hi);
    check_data("mtime_hi", now_hi, start_hi, 0);
    if (now_lo < target_lo) begin
      $display("FAILED mtime_lo: got 0x%h, below mtimecmp_lo 0x%h", now_lo, target_lo);
      stop_on_failure();
    end
    write_reg(reg_addr(sel_mtimecmp, 1'b0), '1);
    write_reg(reg_addr(sel_mtimecmp, 1'b1), '1);
    cycles = 0;
    while (timer_irq !== 1'b0 && cycles < drop_timeout) begin
      @(negedge clock);
      cycles++;
    end
    if (timer_irq !== 1'b0) begin
      abort_with("timer_irq stayed high after mtimecmp was set to all ones");
    end
  endtask

  task automatic test_busy();
    logic [xlen-1:0] value;
    // let any toggling from earlier accesses settle.
    repeat (2) @(negedge clock);
    check_flag("busy", busy, 1'b0);
    read_reg(reg_addr(sel_msip, 1'b0), value);
    check_flag("busy", busy, 1'b1);
    @(negedge clock);
    check_flag("busy", busy, 1'b0);
    addr    = reg_addr(sel_unmapped, 1'b0);
    wr_data = '0;
    wr_en   = 1'b1;
    @(negedge clock);
    check_flag("busy", busy, 1'b1);
    @(negedge clock);
    check_flag("busy", busy, 1'b0);
    wr_en = 1'b0;
  endtask

  initial begin
    rd_en      = 1'b0;
    wr_en      = 1'b0;
    addr       = '0;
    wr_data    = '0;
    lfsr_state = lfsr_seed;
    fail_count = 0;
    wait_reset_release();
    test_reset_state();
    test_msip();
    test_mtimecmp_halves();
    test_mtime();
    test_timer_irq();
    test_busy();
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== clint_timer_regs.sv ====
`timescale 1ns/1ps

module clint_timer_regs
  import clint_pkg::*;
#(
  parameter int xlen        = default_xlen,
  parameter int tick_cycles = default_tick_cycles
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   msip_we,
  input  logic                   mtime_we,
  input  logic                   mtimecmp_we,
  input  logic                   upper_half,
  input  logic [xlen-1:0]        wr_data,
  output logic [xlen-1:0]        msip_q,
  output logic [timer_width-1:0] mtime_q,
  output logic [timer_width-1:0] mtimecmp_q
);

  // a period of one clock still needs a one-bit prescaler.
  localparam int presc_w = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;
  localparam logic [presc_w-1:0] presc_last = presc_w'(tick_cycles - 1);

  logic [presc_w-1:0]     presc_q;
  logic                   tick;
  logic [timer_width-1:0] mtime_wr_value;
  logic [timer_width-1:0] mtimecmp_wr_value;

  // free-running prescaler, wraps at tick_cycles-1.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      presc_q <= '0;
    end else if (tick) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + presc_w'(1);
    end
  end

  assign tick = (presc_q == presc_last);

  // 32-bit writes replace one half and keep the other.
  generate
    if (xlen == half_width) begin : g_half_writes
      assign mtime_wr_value = upper_half ?
                              {wr_data, mtime_q[half_width-1:0]} :
                              {mtime_q[timer_width-1:half_width], wr_data};
      assign mtimecmp_wr_value = upper_half ?
                                 {wr_data, mtimecmp_q[half_width-1:0]} :
                                 {mtimecmp_q[timer_width-1:half_width], wr_data};
    end else begin : g_full_writes
      assign mtime_wr_value    = wr_data;
      assign mtimecmp_wr_value = wr_data;
    end
  endgenerate

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      msip_q <= '0;
    end else if (msip_we) begin
      msip_q <= wr_data;
    end
  end

  // a load wins over the tick of the same cycle.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtime_q <= '0;
    end else if (mtime_we) begin
      mtime_q <= mtime_wr_value;
    end else if (tick) begin
      mtime_q <= mtime_q + timer_width'(1);
    end
  end

  // all ones keeps the timer interrupt off until software programs it.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtimecmp_q <= '1;
    end else if (mtimecmp_we) begin
      mtimecmp_q <= mtimecmp_wr_value;
    end
  end

  a_mtime_step : assert property (
    @(posedge clock) disable iff (reset)
    !mtime_we |=> (mtime_q == $past(mtime_q)) ||
                  (mtime_q == $past(mtime_q) + timer_width'(1))
  ) else $error("mtime moved by more than one without a write");

endmodule

// ==== clint_top.sv ====
`timescale 1ns/1ps

module clint_top
  import clint_pkg::*;
#(
  parameter int xlen        = default_xlen,
  parameter int tick_cycles = default_tick_cycles
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   rd_en,
  input  logic                   wr_en,
  input  logic [2:0]             addr,
  input  logic [xlen-1:0]        wr_data,
  output logic [xlen-1:0]        rd_data,
  output logic                   busy,
  output logic [xlen-1:0]        msip,
  output logic [timer_width-1:0] mtime,
  output logic [timer_width-1:0] mtimecmp,
  output logic                   timer_irq,
  output logic                   software_irq
);

  logic           msip_we;
  logic           mtime_we;
  logic           mtimecmp_we;
  logic           upper_half;
  clint_reg_sel_e read_sel;

  if (!(xlen == 32 || xlen == 64)) begin : g_bad_xlen
    $error("clint_top supports xlen 32 or 64 only");
  end

  clint_access_decode u_decode (
    .clock       (clock),
    .reset       (reset),
    .rd_en       (rd_en),
    .wr_en       (wr_en),
    .addr        (addr),
    .msip_we     (msip_we),
    .mtime_we    (mtime_we),
    .mtimecmp_we (mtimecmp_we),
    .upper_half  (upper_half),
    .read_sel    (read_sel),
    .busy        (busy)
  );

  clint_timer_regs #(
    .xlen        (xlen),
    .tick_cycles (tick_cycles)
  ) u_regs (
    .clock       (clock),
    .reset       (reset),
    .msip_we     (msip_we),
    .mtime_we    (mtime_we),
    .mtimecmp_we (mtimecmp_we),
    .upper_half  (upper_half),
    .wr_data     (wr_data),
    .msip_q      (msip),
    .mtime_q     (mtime),
    .mtimecmp_q  (mtimecmp)
  );

  clint_readback_irq #(
    .xlen (xlen)
  ) u_readback (
    .clock        (clock),
    .reset        (reset),
    .read_sel     (read_sel),
    .upper_half   (upper_half),
    .msip_q       (msip),
    .mtime_q      (mtime),
    .mtimecmp_q   (mtimecmp),
    .rd_data      (rd_data),
    .timer_irq    (timer_irq),
    .software_irq (software_irq)
  );

endmodule

// ==== sources.f ====
clint_pkg.sv
clint_access_decode.sv
clint_timer_regs.sv
clint_readback_irq.sv
clint_top.sv
tb_clock_gen.sv
clint_tb.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period  = 4,
  parameter int reset_cycles = 5
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // reset drops on a falling edge, away from the DUT's active edge.
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule
